/* Makefile */
# Verilator build and run of the ECC randomness unit testbench
# pass is decided by searching the log for the pass line

TOP := ecc_drbg_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* compile.f */
+incdir+verilog
verilog/ecc_drbg_pkg.sv
verilog/drbg_mix_core.sv
verilog/ecc_drbg_sequencer.sv
verilog/ecc_drbg_top.sv
dv/tb_clock_gen.sv
dv/ecc_drbg_tb.sv

/* dv/ecc_drbg_tb.sv */
//------------------------------
// testbench for the ECC randomness unit
// runs a table of keygen and sign runs against a model of mixer and timing
//------------------------------

`include "ecc_drbg_consts.svh"

module ecc_drbg_tb;

    import ecc_drbg_pkg::*;

    localparam int NUM_ROWS = 8;
    localparam int R = `ECC_MIX_ROUNDS;
    // en sample to ready high again
    localparam int KEYGEN_LAT = 4 * (R + 2) + 2;
    localparam int SIGN_LAT = 5 * (R + 2) + 2;
    // counter offset from the en cycle at the final init command
    localparam int KEYGEN_INIT_OFS = 3 * (R + 2) + 2;
    localparam int SIGN_INIT_OFS = 4 * (R + 2) + 2;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 60 + 100;
    // busy pulses, counted from the en sample
    localparam int BUSY_AT_A = 3;
    localparam int BUSY_AT_B = 27;

    //------------------------------
    // stimulus table
    //------------------------------
    // mode 1 is sign, zero_at 0 means no zeroize
    typedef struct packed {
        logic      mode;
        logic      busy_pulse;
        int        zero_at;
        ecc_word_t seed;
        ecc_word_t nonce;
        ecc_word_t key;
        ecc_word_t msg;
        ecc_word_t iv;
        ecc_word_t exp_seed;
        ecc_word_t exp_lambda;
        ecc_word_t exp_scalar;
        ecc_word_t exp_masking;
        ecc_word_t exp_drbg;
        int        exp_lat;
    } row_t;

    row_t      tbl [NUM_ROWS];

    logic      clk;
    logic      reset_n;
    logic      zeroize;
    logic      keygen_sign;
    logic      en;
    logic      ready;
    ecc_word_t keygen_seed;
    ecc_word_t keygen_nonce;
    ecc_word_t priv_key;
    ecc_word_t hashed_msg;
    ecc_word_t iv;
    ecc_word_t lambda;
    ecc_word_t scalar_rnd;
    ecc_word_t masking_rnd;
    ecc_word_t drbg;

    // model state carried from run to run
    ecc_word_t m_seed;
    ecc_word_t m_masking;
    ecc_cnt_t  cnt_model;

    int        seed_var = 26656;
    int        cycle_cnt = 0;
    int        row_errs;
    int        pass_cnt;
    int        fail_cnt;

    tb_clock_gen i_clock_gen
    (
        .clk     (clk),
        .reset_n (reset_n)
    );

    ecc_drbg_top i_dut
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize      (zeroize),
        .keygen_sign  (keygen_sign),
        .en           (en),
        .ready        (ready),
        .keygen_seed  (keygen_seed),
        .keygen_nonce (keygen_nonce),
        .priv_key     (priv_key),
        .hashed_msg   (hashed_msg),
        .iv           (iv),
        .lambda       (lambda),
        .scalar_rnd   (scalar_rnd),
        .masking_rnd  (masking_rnd),
        .drbg         (drbg)
    );

    // free-running counter as the DUT should see it
    always @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            cnt_model <= '0;
        else if (zeroize)
            cnt_model <= '0;
        else
            cnt_model <= cnt_model + ecc_cnt_t'(1);
    end

    // run limit
    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("timeout: no finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    //------------------------------
    // reference model
    //------------------------------
    function automatic ecc_word_t rotl(input ecc_word_t v);
        return {v[`ECC_WORD_W-`ECC_MIX_ROT-1:0], v[`ECC_WORD_W-1:`ECC_WORD_W-`ECC_MIX_ROT]};
    endfunction

    // R rounds, unreduced
    function automatic ecc_word_t mix_chain(input ecc_word_t v, input ecc_word_t key);
        ecc_word_t x;
        int        i;
        x = v;
        for (i = 0; i < R; i++)
            x = rotl(x) ^ (x + key);
        return x;
    endfunction

    function automatic ecc_word_t reduce(input ecc_word_t v);
        ecc_word_t order;
        order = `ECC_GROUP_ORDER;
        if (v < order)
            return v;
        return v - order;
    endfunction

    function automatic ecc_word_t spread(input ecc_cnt_t c);
        return {(`ECC_WORD_W / `ECC_CNT_W){c}};
    endfunction

    function automatic string mode_name(input logic m);
        return m ? "sign" : "keygen";
    endfunction

    // c is the counter in the cycle en is sampled
    task automatic predict_run(input int idx, input ecc_cnt_t c);
        ecc_word_t key;
        ecc_word_t v;
        ecc_word_t v_fin;
        ecc_cnt_t  c_fin;
        key = tbl[idx].iv ^ spread(c);
        v = mix_chain(m_seed ^ spread(c + ecc_cnt_t'(1)), key);
        tbl[idx].exp_seed = reduce(v);
        v = mix_chain(v, key);
        tbl[idx].exp_lambda = reduce(v);
        v = mix_chain(v, key);
        tbl[idx].exp_scalar = reduce(v);
        if (tbl[idx].mode)
        begin
            v = mix_chain(v, key);
            tbl[idx].exp_masking = reduce(v);
            c_fin = c + ecc_cnt_t'(SIGN_INIT_OFS);
            v_fin = mix_chain(tbl[idx].exp_seed ^ spread(c_fin), tbl[idx].key ^ tbl[idx].msg);
            tbl[idx].exp_lat = SIGN_LAT;
        end
        else
        begin
            tbl[idx].exp_masking = m_masking;
            c_fin = c + ecc_cnt_t'(KEYGEN_INIT_OFS);
            v_fin = mix_chain(tbl[idx].exp_seed ^ spread(c_fin), tbl[idx].seed ^ tbl[idx].nonce);
            tbl[idx].exp_lat = KEYGEN_LAT;
        end
        tbl[idx].exp_drbg = reduce(v_fin);
    endtask

    task automatic fill_row(input int idx, input logic mode, input logic busy, input int zero_at);
        tbl[idx] = '0;
        tbl[idx].mode = mode;
        tbl[idx].busy_pulse = busy;
        tbl[idx].zero_at = zero_at;
        tbl[idx].seed = {$random(seed_var), $random(seed_var)};
        tbl[idx].nonce = {$random(seed_var), $random(seed_var)};
        tbl[idx].key = {$random(seed_var), $random(seed_var)};
        tbl[idx].msg = {$random(seed_var), $random(seed_var)};
        tbl[idx].iv = {$random(seed_var), $random(seed_var)};
    endtask

    //------------------------------
    // checks
    //------------------------------
    task automatic check_word(input string name, input ecc_word_t got, input ecc_word_t exp);
        assert (got === exp)
        else
        begin
            $display("Error: %s got %h expected %h", name, got, exp);
            row_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp)
        else
        begin
            $display("Error: %s got %h expected %h", name, got, exp);
            row_errs++;
        end
    endtask

    task automatic tally(input string what);
        $display("%s: %s", what, (row_errs == 0) ? "ok" : "bad");
        if (row_errs == 0)
            pass_cnt++;
        else
            fail_cnt++;
    endtask

    // entered 1 unit after an edge, leaves the same way
    task automatic run_row(input int idx);
        int         lat;
        logic       finished;
        logic       zapped;
        seq_state_e zap_state;
        row_errs = 0;
        lat = 0;
        finished = 1'b0;
        zapped = 1'b0;
        zap_state = SEQ_IDLE;
        keygen_sign = tbl[idx].mode;
        keygen_seed = tbl[idx].seed;
        keygen_nonce = tbl[idx].nonce;
        priv_key = tbl[idx].key;
        hashed_msg = tbl[idx].msg;
        iv = tbl[idx].iv;
        en = 1'b1;
        predict_run(idx, cnt_model);
        @(posedge clk);
        #1;
        en = 1'b0;
        while (!finished)
        begin
            @(posedge clk);
            #1;
            lat++;
            en = tbl[idx].busy_pulse && (lat == BUSY_AT_A || lat == BUSY_AT_B);
            if (zeroize)
            begin
                zeroize = 1'b0;
                zapped = 1'b1;
                finished = 1'b1;
            end
            else if (tbl[idx].zero_at != 0 && lat == tbl[idx].zero_at)
            begin
                zeroize = 1'b1;
                zap_state = i_dut.i_sequencer.state_reg;
            end
            else if (ready === 1'b1)
                finished = 1'b1;
        end
        if (zapped)
        begin
            // everything back to reset values one cycle later
            check_bit("ready", ready, 1'b1);
            check_word("lambda", lambda, '0);
            check_word("scalar_rnd", scalar_rnd, '0);
            check_word("masking_rnd", masking_rnd, '0);
            check_word("drbg", drbg, '0);
            m_seed = `ECC_LFSR_INIT_SEED;
            m_masking = '0;
            tally($sformatf("row %0d %s zeroized in %s", idx, mode_name(tbl[idx].mode),
                            zap_state.name()));
        end
        else
        begin
            assert (lat == tbl[idx].exp_lat)
            else
            begin
                $display("ready came back %0d cycles after en instead of %0d",
                         lat, tbl[idx].exp_lat);
                row_errs++;
            end
            check_word("lambda", lambda, tbl[idx].exp_lambda);
            check_word("scalar_rnd", scalar_rnd, tbl[idx].exp_scalar);
            check_word("masking_rnd", masking_rnd, tbl[idx].exp_masking);
            check_word("drbg", drbg, tbl[idx].exp_drbg);
            // seed register chains into the next run
            m_seed = tbl[idx].exp_seed;
            m_masking = tbl[idx].exp_masking;
            tally($sformatf("row %0d %s%s, %0d cycles", idx, mode_name(tbl[idx].mode),
                            tbl[idx].busy_pulse ? " busy" : "", lat));
        end
    endtask

    //------------------------------
    // main sequence
    //------------------------------
    initial
    begin
        int i;
        zeroize = 1'b0;
        en = 1'b0;
        keygen_sign = 1'b0;
        keygen_seed = '0;
        keygen_nonce = '0;
        priv_key = '0;
        hashed_msg = '0;
        iv = '0;
        pass_cnt = 0;
        fail_cnt = 0;
        m_seed = `ECC_LFSR_INIT_SEED;
        m_masking = '0;
        fill_row(0, 1'b0, 1'b0, 0);
        fill_row(1, 1'b1, 1'b0, 0);
        fill_row(2, 1'b0, 1'b1, 0);
        fill_row(3, 1'b1, 1'b1, 0);
        fill_row(4, 1'b1, 1'b0, 20);
        fill_row(5, 1'b0, 1'b0, 0);
        fill_row(6, 1'b0, 1'b0, 35);
        fill_row(7, 1'b1, 1'b0, 0);
        wait (reset_n === 1'b1);
        @(posedge clk);
        #1;
        row_errs = 0;
        check_bit("ready", ready, 1'b1);
        check_word("lambda", lambda, '0);
        check_word("scalar_rnd", scalar_rnd, '0);
        check_word("masking_rnd", masking_rnd, '0);
        check_word("drbg", drbg, '0);
        tally("reset state");
        for (i = 0; i < NUM_ROWS; i++)
        begin
            run_row(i);
            // gap of 0 to 2 idle cycles
            repeat (i % 3)
            begin
                @(posedge clk);
                #1;
            end
        end
        $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

/* dv/tb_clock_gen.sv */
//------------------------------
// testbench clock and reset
// period 4, reset_n held low for 10 cycles
//------------------------------

module tb_clock_gen
(
    output logic clk,
    output logic reset_n
);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // release 1 unit after an edge, clear of the sampling edge
    initial
    begin
        reset_n = 1'b0;
        repeat (10) @(posedge clk);
        #1 reset_n = 1'b1;
    end

endmodule

/* verilog/drbg_mix_core.sv */
//------------------------------
// keyed rotate-add-xor mixer with the HMAC-DRBG command interface
// init loads key and state, next continues the chain
//------------------------------

`include "ecc_drbg_consts.svh"

module drbg_mix_core
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize,
    input  logic                    init_cmd,
    input  logic                    next_cmd,
    input  ecc_drbg_pkg::ecc_word_t lfsr_seed,
    input  ecc_drbg_pkg::ecc_word_t entropy,
    input  ecc_drbg_pkg::ecc_word_t nonce,
    output logic                    ready,
    output logic                    valid,
    output ecc_drbg_pkg::ecc_word_t result
);

    import ecc_drbg_pkg::*;

    // round counter just wide enough for the full round count
    localparam int ROUND_W = $clog2(`ECC_MIX_ROUNDS + 1);
    localparam logic [ROUND_W-1:0] ROUND_FULL = ROUND_W'(`ECC_MIX_ROUNDS);
    localparam logic [ROUND_W-1:0] ROUND_LAST = ROUND_W'(1);
    localparam ecc_word_t GROUP_ORDER = `ECC_GROUP_ORDER;

    ecc_word_t          key_reg;
    ecc_word_t          v_reg;
    logic [ROUND_W-1:0] round_cnt;
    logic               busy;
    logic               valid_reg;
    logic               accept;

    //------------------------------
    // one mixing round
    //------------------------------
    // v rotated left, xor with v plus key (mod 2^64)
    function automatic ecc_word_t mix_round(input ecc_word_t v, input ecc_word_t k);
        ecc_word_t rot;
        rot = (v << `ECC_MIX_ROT) | (v >> (`ECC_WORD_W - `ECC_MIX_ROT));
        return rot ^ (v + k);
    endfunction

    // commands only taken while idle
    assign accept = (init_cmd | next_cmd) & ~busy;

    //------------------------------
    // key and chaining state
    //------------------------------
    // init rekeys, next keeps key and v
    // v stays unreduced so a following next continues the chain
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            key_reg <= '0;
            v_reg   <= '0;
        end
        else if (zeroize)
        begin
            key_reg <= '0;
            v_reg   <= '0;
        end
        else if (accept && init_cmd)
        begin
            key_reg <= entropy ^ nonce;
            v_reg   <= lfsr_seed;
        end
        else if (busy)
        begin
            v_reg <= mix_round(v_reg, key_reg);
        end
    end

    //------------------------------
    // round control
    //------------------------------
    // command edge loads the count, one round per busy cycle
    // valid comes up on the edge of the last round
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            round_cnt <= '0;
            busy      <= 1'b0;
            valid_reg <= 1'b0;
        end
        else if (zeroize)
        begin
            round_cnt <= '0;
            busy      <= 1'b0;
            valid_reg <= 1'b0;
        end
        else if (accept)
        begin
            round_cnt <= ROUND_FULL;
            busy      <= 1'b1;
            valid_reg <= 1'b0;
        end
        else if (busy)
        begin
            round_cnt <= round_cnt - ROUND_LAST;
            // last round done, hand result out
            if (round_cnt == ROUND_LAST)
            begin
                busy      <= 1'b0;
                valid_reg <= 1'b1;
            end
        end
    end

    // ready and valid both stay up until the next command
    assign ready = ~busy;
    assign valid = valid_reg;

    // single conditional subtract, v is below twice the order
    assign result = (v_reg >= GROUP_ORDER) ? (v_reg - GROUP_ORDER) : v_reg;

endmodule

/* verilog/ecc_drbg_consts.svh */
//------------------------------
// sizing and constants for the ECC randomness unit
// included by the package, the mixer core and the sequencer
//------------------------------

`ifndef ECC_DRBG_CONSTS_SVH
`define ECC_DRBG_CONSTS_SVH

// width of every data word
`define ECC_WORD_W 64

// free-running counter width
// four copies of it make one counter nonce
`define ECC_CNT_W 16

// mixer rounds run for each init or next command
`define ECC_MIX_ROUNDS 8

// left-rotate amount applied in every round
`define ECC_MIX_ROT 13

// modulus for the final reduction of each result
// largest 64-bit prime, stands in for the curve group order
`define ECC_GROUP_ORDER 64'hffffffffffffffc5

// seed register value after reset and after zeroize
`define ECC_LFSR_INIT_SEED 64'h5a3c96e1d2b4870f

`endif

/* verilog/ecc_drbg_pkg.sv */
//------------------------------
// shared types of the ECC randomness unit
// word and counter types, sequencer state encoding
//------------------------------

`include "ecc_drbg_consts.svh"

package ecc_drbg_pkg;

    // one data word: seeds, nonces, keys and results
    typedef logic [`ECC_WORD_W-1:0] ecc_word_t;

    // free-running cycle counter
    typedef logic [`ECC_CNT_W-1:0] ecc_cnt_t;

    //------------------------------
    // sequencer states
    //------------------------------
    // command states run one core command each
    // rnd_done picks the keygen or sign branch
    typedef enum logic [3:0] {
        SEQ_IDLE     = 4'd0,
        SEQ_LFSR     = 4'd1,
        SEQ_LAMBDA   = 4'd2,
        SEQ_SCALAR   = 4'd3,
        SEQ_RND_DONE = 4'd4,
        SEQ_MASKING  = 4'd5,
        SEQ_KEYGEN   = 4'd6,
        SEQ_SIGN     = 4'd7,
        SEQ_DONE     = 4'd8
    } seq_state_e;

endpackage

/* verilog/ecc_drbg_sequencer.sv */
//------------------------------
// command sequencer for the randomness core
// orders init/next per mode, owns counter, seed and output registers
//------------------------------

`include "ecc_drbg_consts.svh"

module ecc_drbg_sequencer
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize,
    input  logic                    keygen_sign,
    input  logic                    en,
    input  ecc_drbg_pkg::ecc_word_t keygen_seed,
    input  ecc_drbg_pkg::ecc_word_t keygen_nonce,
    input  ecc_drbg_pkg::ecc_word_t priv_key,
    input  ecc_drbg_pkg::ecc_word_t hashed_msg,
    input  ecc_drbg_pkg::ecc_word_t iv,
    input  logic                    core_ready,
    input  logic                    core_valid,
    input  ecc_drbg_pkg::ecc_word_t core_result,
    output logic                    ready,
    output ecc_drbg_pkg::ecc_word_t lambda,
    output ecc_drbg_pkg::ecc_word_t scalar_rnd,
    output ecc_drbg_pkg::ecc_word_t masking_rnd,
    output ecc_drbg_pkg::ecc_word_t drbg,
    output logic                    init_cmd,
    output logic                    next_cmd,
    output ecc_drbg_pkg::ecc_word_t core_seed,
    output ecc_drbg_pkg::ecc_word_t core_entropy,
    output ecc_drbg_pkg::ecc_word_t core_nonce
);

    import ecc_drbg_pkg::*;

    seq_state_e state_reg;
    seq_state_e state_next;
    seq_state_e state_last;

    logic       first_round;
    logic       core_valid_last;
    logic       done_edge;
    logic       start;

    ecc_cnt_t   counter;
    ecc_word_t  counter_nonce;
    ecc_word_t  nonce_reg;
    ecc_word_t  seed_reg;

    ecc_word_t  lambda_reg;
    ecc_word_t  scalar_reg;
    ecc_word_t  masking_reg;
    ecc_word_t  drbg_reg;

    // first cycle of a state, when the command goes out
    assign first_round = (state_reg != state_last);
    // result arrival, valid stays high so compare with last cycle
    assign done_edge   = core_valid & ~core_valid_last;
    // en outside idle is dropped
    assign start       = en & core_ready & (state_reg == SEQ_IDLE);

    //------------------------------
    // counter and seed
    //------------------------------
    // counter copied across the word
    assign counter_nonce = {(`ECC_WORD_W / `ECC_CNT_W){counter}};
    // live counter folded into the seed the core sees
    assign core_seed     = seed_reg ^ counter_nonce;

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            counter <= '0;
        else if (zeroize)
            counter <= '0;
        else
            counter <= counter + 1'b1;
    end

    // nonce snapshot taken when a run starts
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            nonce_reg <= '0;
        else if (zeroize)
            nonce_reg <= '0;
        else if (start)
            nonce_reg <= counter_nonce;
    end

    //------------------------------
    // core inputs
    //------------------------------
    // iv runs use the snapshot nonce
    // final init takes the mode's own key material
    always_comb
    begin
        unique case (state_reg)
            SEQ_LFSR, SEQ_LAMBDA, SEQ_SCALAR, SEQ_MASKING:
            begin
                core_entropy = iv;
                core_nonce   = nonce_reg;
            end
            SEQ_KEYGEN:
            begin
                core_entropy = keygen_seed;
                core_nonce   = keygen_nonce;
            end
            SEQ_SIGN:
            begin
                core_entropy = priv_key;
                core_nonce   = hashed_msg;
            end
            default:
            begin
                core_entropy = '0;
                core_nonce   = nonce_reg;
            end
        endcase
    end

    // one-cycle command on state entry, only to a ready core
    always_comb
    begin
        init_cmd = 1'b0;
        next_cmd = 1'b0;
        if (first_round && core_ready)
        begin
            unique case (state_reg)
                SEQ_LFSR, SEQ_KEYGEN, SEQ_SIGN:        init_cmd = 1'b1;
                SEQ_LAMBDA, SEQ_SCALAR, SEQ_MASKING:   next_cmd = 1'b1;
                default:                               init_cmd = 1'b0;
            endcase
        end
    end

    //------------------------------
    // FSM
    //------------------------------
    always_comb
    begin
        state_next = state_reg;
        unique case (state_reg)
            SEQ_IDLE:     state_next = start ? SEQ_LFSR : SEQ_IDLE;
            SEQ_LFSR:     state_next = done_edge ? SEQ_LAMBDA : SEQ_LFSR;
            SEQ_LAMBDA:   state_next = done_edge ? SEQ_SCALAR : SEQ_LAMBDA;
            SEQ_SCALAR:   state_next = done_edge ? SEQ_RND_DONE : SEQ_SCALAR;
            // mode branch
            SEQ_RND_DONE: state_next = keygen_sign ? SEQ_MASKING : SEQ_KEYGEN;
            SEQ_MASKING:  state_next = done_edge ? SEQ_SIGN : SEQ_MASKING;
            SEQ_KEYGEN:   state_next = done_edge ? SEQ_DONE : SEQ_KEYGEN;
            SEQ_SIGN:     state_next = done_edge ? SEQ_DONE : SEQ_SIGN;
            SEQ_DONE:     state_next = SEQ_IDLE;
            default:      state_next = SEQ_IDLE;
        endcase
    end

    // state, previous state and previous valid
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            state_reg       <= SEQ_IDLE;
            state_last      <= SEQ_IDLE;
            core_valid_last <= 1'b0;
        end
        else if (zeroize)
        begin
            state_reg       <= SEQ_IDLE;
            state_last      <= SEQ_IDLE;
            core_valid_last <= 1'b0;
        end
        else
        begin
            state_reg       <= state_next;
            state_last      <= state_reg;
            core_valid_last <= core_valid;
        end
    end

    //------------------------------
    // result capture
    //------------------------------
    // lfsr result reseeds, the rest go to the outputs
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            seed_reg    <= `ECC_LFSR_INIT_SEED;
            lambda_reg  <= '0;
            scalar_reg  <= '0;
            masking_reg <= '0;
            drbg_reg    <= '0;
        end
        else if (zeroize)
        begin
            seed_reg    <= `ECC_LFSR_INIT_SEED;
            lambda_reg  <= '0;
            scalar_reg  <= '0;
            masking_reg <= '0;
            drbg_reg    <= '0;
        end
        else if (done_edge)
        begin
            unique case (state_reg)
                SEQ_LFSR:             seed_reg    <= core_result;
                SEQ_LAMBDA:           lambda_reg  <= core_result;
                SEQ_SCALAR:           scalar_reg  <= core_result;
                SEQ_MASKING:          masking_reg <= core_result;
                SEQ_KEYGEN, SEQ_SIGN: drbg_reg    <= core_result;
                default:              drbg_reg    <= drbg_reg;
            endcase
        end
    end

    assign ready       = (state_reg == SEQ_IDLE);
    assign lambda      = lambda_reg;
    assign scalar_rnd  = scalar_reg;
    assign masking_rnd = masking_reg;
    assign drbg        = drbg_reg;

endmodule

/* verilog/ecc_drbg_top.sv */
//------------------------------
// ECC randomness unit top level
// sequencer driving the mixer core, loose ports outside
//------------------------------

module ecc_drbg_top
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize,
    input  logic                    keygen_sign,
    input  logic                    en,
    output logic                    ready,
    input  ecc_drbg_pkg::ecc_word_t keygen_seed,
    input  ecc_drbg_pkg::ecc_word_t keygen_nonce,
    input  ecc_drbg_pkg::ecc_word_t priv_key,
    input  ecc_drbg_pkg::ecc_word_t hashed_msg,
    input  ecc_drbg_pkg::ecc_word_t iv,
    output ecc_drbg_pkg::ecc_word_t lambda,
    output ecc_drbg_pkg::ecc_word_t scalar_rnd,
    output ecc_drbg_pkg::ecc_word_t masking_rnd,
    output ecc_drbg_pkg::ecc_word_t drbg
);

    import ecc_drbg_pkg::*;

    //------------------------------
    // sequencer to core
    //------------------------------
    logic      init_cmd;
    logic      next_cmd;
    logic      core_ready;
    logic      core_valid;
    ecc_word_t core_seed;
    ecc_word_t core_entropy;
    ecc_word_t core_nonce;
    ecc_word_t core_result;

    ecc_drbg_sequencer i_sequencer
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize      (zeroize),
        .keygen_sign  (keygen_sign),
        .en           (en),
        .keygen_seed  (keygen_seed),
        .keygen_nonce (keygen_nonce),
        .priv_key     (priv_key),
        .hashed_msg   (hashed_msg),
        .iv           (iv),
        .core_ready   (core_ready),
        .core_valid   (core_valid),
        .core_result  (core_result),
        .ready        (ready),
        .lambda       (lambda),
        .scalar_rnd   (scalar_rnd),
        .masking_rnd  (masking_rnd),
        .drbg         (drbg),
        .init_cmd     (init_cmd),
        .next_cmd     (next_cmd),
        .core_seed    (core_seed),
        .core_entropy (core_entropy),
        .core_nonce   (core_nonce)
    );

    // zeroize reaches both blocks
    drbg_mix_core i_core
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .init_cmd  (init_cmd),
        .next_cmd  (next_cmd),
        .lfsr_seed (core_seed),
        .entropy   (core_entropy),
        .nonce     (core_nonce),
        .ready     (core_ready),
        .valid     (core_valid),
        .result    (core_result)
    );

endmodule
